// ==== verilog/cr16_params.svh ====
`ifndef CR16_PARAMS_SVH
`define CR16_PARAMS_SVH

////////////////////
// Datapath widths
////////////////////

`define CR16_WORD_WIDTH     16
`define CR16_REG_ADDR_WIDTH 4
`define CR16_NUM_REGS       16
`define CR16_OP_WIDTH       4
`define CR16_NUM_FLAGS      5

// Status flag bit positions
`define CR16_FLAG_C 0
`define CR16_FLAG_L 1
`define CR16_FLAG_F 2
`define CR16_FLAG_Z 3
`define CR16_FLAG_N 4

////////////////////
// Operation codes
////////////////////

// Major opcode 0000 means register form, op in bits 7:4
`define CR16_OP_REGFORM 4'b0000
`define CR16_OP_AND     4'b0001
`define CR16_OP_OR      4'b0010
`define CR16_OP_XOR     4'b0011
`define CR16_OP_ADD     4'b0101
`define CR16_OP_LSH     4'b1000
`define CR16_OP_SUB     4'b1001
`define CR16_OP_CMP     4'b1011
`define CR16_OP_MOV     4'b1101
`define CR16_OP_LUI     4'b1111

`endif

// ==== verilog/cr16_pkg.sv ====
`include "cr16_params.svh"

package cr16_pkg;

  // Data word, one register wide
  typedef logic [`CR16_WORD_WIDTH-1:0] word_t;

  // Register file index
  typedef logic [`CR16_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // ALU operation, same encoding as the major opcode
  typedef logic [`CR16_OP_WIDTH-1:0] alu_op_t;

  // Status flags
  // Indexed by the CR16_FLAG_* positions
  typedef logic [`CR16_NUM_FLAGS-1:0] flags_t;

  // Raw instruction word
  typedef logic [`CR16_WORD_WIDTH-1:0] instr_t;

endpackage

// ==== verilog/cr16_alu.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_alu (
  input  cr16_pkg::word_t   alu_a,
  input  cr16_pkg::word_t   alu_b,
  input  cr16_pkg::alu_op_t alu_op,
  output cr16_pkg::word_t   alu_result,
  output cr16_pkg::flags_t  alu_flags
);

  import cr16_pkg::*;

  localparam int SIGN_BIT = `CR16_WORD_WIDTH - 1;
  localparam int HALF     = `CR16_WORD_WIDTH / 2;

  // One extra bit on top for carry and borrow
  logic [`CR16_WORD_WIDTH:0] sum_ext;
  logic [`CR16_WORD_WIDTH:0] diff_ext;
  // Right shift count, negated 4-bit field
  logic [3:0]                rshift_amt;
  word_t                     shift_res;

  ////////////////////
  // Arithmetic
  ////////////////////

  assign sum_ext  = {1'b0, alu_a} + {1'b0, alu_b};
  assign diff_ext = {1'b0, alu_a} - {1'b0, alu_b};

  // b[4] picks direction, b[3:0] the count
  assign rshift_amt = ~alu_b[3:0] + 4'd1;
  assign shift_res  = alu_b[4] ? (alu_a >> rshift_amt) : (alu_a << alu_b[3:0]);

  ////////////////////
  // Result and flags
  ////////////////////

  always_comb begin
    // Unlisted ops fall out as zero
    alu_result = '0;
    alu_flags  = '0;
    case (alu_op)
      `CR16_OP_ADD: begin
        alu_result = sum_ext[SIGN_BIT:0];
        alu_flags[`CR16_FLAG_C] = sum_ext[`CR16_WORD_WIDTH];
        // Overflow when like signs give an unlike sign
        alu_flags[`CR16_FLAG_F] = (alu_a[SIGN_BIT] == alu_b[SIGN_BIT]) &&
                                  (sum_ext[SIGN_BIT] != alu_a[SIGN_BIT]);
      end
      `CR16_OP_SUB: begin
        alu_result = diff_ext[SIGN_BIT:0];
        // Borrow out of the top bit
        alu_flags[`CR16_FLAG_C] = diff_ext[`CR16_WORD_WIDTH];
        // Overflow when unlike signs flip away from a
        alu_flags[`CR16_FLAG_F] = (alu_a[SIGN_BIT] != alu_b[SIGN_BIT]) &&
                                  (diff_ext[SIGN_BIT] != alu_a[SIGN_BIT]);
      end
      `CR16_OP_CMP: begin
        // Flags only, result stays zero
        alu_flags[`CR16_FLAG_Z] = (alu_a == alu_b);
        alu_flags[`CR16_FLAG_N] = ($signed(alu_a) > $signed(alu_b));
        alu_flags[`CR16_FLAG_L] = (alu_a > alu_b);
      end
      `CR16_OP_AND: alu_result = alu_a & alu_b;
      `CR16_OP_OR:  alu_result = alu_a | alu_b;
      `CR16_OP_XOR: alu_result = alu_a ^ alu_b;
      `CR16_OP_LSH: alu_result = shift_res;
      // Low byte of b goes to the upper half
      `CR16_OP_LUI: alu_result = {alu_b[HALF-1:0], alu_a[HALF-1:0]};
      `CR16_OP_MOV: alu_result = alu_b;
      default: begin
        alu_result = '0;
        alu_flags  = '0;
      end
    endcase
  end

  // No X may leak out of a fully known operation
  always_comb begin
    if (!$isunknown({alu_a, alu_b, alu_op})) begin
      assert (!$isunknown({alu_result, alu_flags}))
        else $error("cr16_alu: unknown output with known inputs");
    end
  end

endmodule

// ==== verilog/cr16_decode.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_decode (
  input  cr16_pkg::instr_t    instr,
  output cr16_pkg::alu_op_t   alu_op,
  output cr16_pkg::reg_addr_t rdest,
  output cr16_pkg::reg_addr_t rsrc,
  output logic                imm_sel,
  output cr16_pkg::word_t     imm_value,
  output logic                reg_we,
  output cr16_pkg::flags_t    flag_mask,
  output logic                legal
);

  import cr16_pkg::*;

  localparam int IMM_WIDTH = 8;

  alu_op_t major;
  logic    reg_form;
  // Set for ops that take a signed immediate
  logic    sign_ext;
  word_t   imm_sext;
  word_t   imm_zext;

  ////////////////////
  // Field split
  ////////////////////

  assign major    = instr[15:12];
  assign reg_form = (major == `CR16_OP_REGFORM);
  assign rdest    = instr[11:8];
  // Only meaningful in register form
  assign rsrc     = instr[3:0];
  assign alu_op   = reg_form ? instr[7:4] : major;
  assign imm_sel  = ~reg_form;

  // Both extensions of the low byte
  assign imm_sext = {{(`CR16_WORD_WIDTH-IMM_WIDTH){instr[IMM_WIDTH-1]}}, instr[IMM_WIDTH-1:0]};
  assign imm_zext = {{(`CR16_WORD_WIDTH-IMM_WIDTH){1'b0}}, instr[IMM_WIDTH-1:0]};

  ////////////////////
  // Op classes
  ////////////////////

  always_comb begin
    legal     = 1'b1;
    sign_ext  = 1'b0;
    flag_mask = '0;
    case (alu_op)
      `CR16_OP_ADD, `CR16_OP_SUB: begin
        sign_ext = 1'b1;
        flag_mask[`CR16_FLAG_C] = 1'b1;
        flag_mask[`CR16_FLAG_F] = 1'b1;
      end
      `CR16_OP_CMP: begin
        sign_ext = 1'b1;
        flag_mask[`CR16_FLAG_Z] = 1'b1;
        flag_mask[`CR16_FLAG_N] = 1'b1;
        flag_mask[`CR16_FLAG_L] = 1'b1;
      end
      `CR16_OP_MOV: sign_ext = 1'b1;
      // Logic ops, shift and LUI take the byte unsigned
      `CR16_OP_AND, `CR16_OP_OR, `CR16_OP_XOR,
      `CR16_OP_LUI, `CR16_OP_LSH: sign_ext = 1'b0;
      default: begin
        legal    = 1'b0;
        sign_ext = 1'b0;
      end
    endcase
  end

  assign imm_value = sign_ext ? imm_sext : imm_zext;

  // CMP only touches flags
  assign reg_we = legal && (alu_op != `CR16_OP_CMP);

endmodule

// ==== verilog/cr16_regfile.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  cr16_pkg::reg_addr_t waddr,
  input  cr16_pkg::word_t     wdata,
  input  cr16_pkg::reg_addr_t raddr_a,
  input  cr16_pkg::reg_addr_t raddr_b,
  output cr16_pkg::word_t     rdata_a,
  output cr16_pkg::word_t     rdata_b
);

  import cr16_pkg::*;

  // General purpose registers
  word_t regs [`CR16_NUM_REGS];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Architectural state starts at zero
      for (int i = 0; i < `CR16_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Asynchronous, sees a write once the edge has passed
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  // Write strobe must carry a clean address and value
  assert property (@(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown({waddr, wdata}))
    else $error("cr16_regfile: unknown write address or data");

endmodule

// ==== verilog/cr16_writeback.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_writeback (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  logic             legal,
  input  cr16_pkg::word_t  alu_result,
  input  cr16_pkg::flags_t alu_flags,
  input  cr16_pkg::flags_t flag_mask,
  output cr16_pkg::word_t  result,
  output logic             result_valid,
  output logic             illegal_op,
  output cr16_pkg::flags_t flags
);

  import cr16_pkg::*;

  // Accepted and legal this cycle
  logic   take;
  // Masked bits from the ALU, the rest held
  flags_t flags_next;

  assign take       = instr_valid && legal;
  assign flags_next = (flags & ~flag_mask) | (alu_flags & flag_mask);

  ////////////////////
  // Status and result
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags  <= '0;
      result <= '0;
    end else if (take) begin
      flags  <= flags_next;
      result <= alu_result;
    end
  end

  // One-cycle pulses after the accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      illegal_op   <= 1'b0;
    end else begin
      result_valid <= take;
      illegal_op   <= instr_valid && !legal;
    end
  end

  // An instruction ends one way only
  assert property (@(posedge clk) disable iff (!rst_n)
    !(result_valid && illegal_op))
    else $error("cr16_writeback: result_valid and illegal_op together");

endmodule

// ==== verilog/cr16_exec.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_exec (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  cr16_pkg::instr_t  instr,
  output cr16_pkg::word_t   result,
  output logic              result_valid,
  output logic              illegal_op,
  output cr16_pkg::flags_t  flags
);

  import cr16_pkg::*;

  // Decode outputs
  alu_op_t   alu_op;
  reg_addr_t rdest;
  reg_addr_t rsrc;
  logic      imm_sel;
  word_t     imm_value;
  logic      reg_we;
  flags_t    flag_mask;
  logic      legal;

  // Operands and ALU outputs
  word_t     rdata_a;
  word_t     rdata_b;
  word_t     operand_b;
  word_t     alu_result;
  flags_t    alu_flags;
  logic      rf_we;

  cr16_decode cr16_decode_i (
    .instr     (instr),
    .alu_op    (alu_op),
    .rdest     (rdest),
    .rsrc      (rsrc),
    .imm_sel   (imm_sel),
    .imm_value (imm_value),
    .reg_we    (reg_we),
    .flag_mask (flag_mask),
    .legal     (legal)
  );

  // Destination doubles as operand a
  cr16_regfile cr16_regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (rf_we),
    .waddr   (rdest),
    .wdata   (alu_result),
    .raddr_a (rdest),
    .raddr_b (rsrc),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  // Immediate form replaces the source register
  assign operand_b = imm_sel ? imm_value : rdata_b;
  assign rf_we     = instr_valid && reg_we;

  cr16_alu cr16_alu_i (
    .alu_a      (rdata_a),
    .alu_b      (operand_b),
    .alu_op     (alu_op),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  cr16_writeback cr16_writeback_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .legal        (legal),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .flag_mask    (flag_mask),
    .result       (result),
    .result_valid (result_valid),
    .illegal_op   (illegal_op),
    .flags        (flags)
  );

endmodule

// ==== sim/cr16_exec_tb.sv ====
`timescale 1ns/10ps
`include "cr16_params.svh"

module cr16_exec_tb;

  import cr16_pkg::*;

  // One table row, expected values filled by the model
  typedef struct packed {
    instr_t instr;
    logic   exp_valid;
    word_t  exp_result;
    flags_t exp_flags;
    logic   exp_illegal;
  } step_t;

  logic   clk;
  logic   rst_n;
  logic   instr_valid;
  instr_t instr;
  word_t  result;
  logic   result_valid;
  logic   illegal_op;
  flags_t flags;

  step_t  steps[$];
  // Architectural state as the model sees it
  word_t  model_regs[`CR16_NUM_REGS];
  flags_t model_flags;
  integer seed;
  int     mismatches;
  int     failures;
  int     cycles;
  int     cycle_limit;

  cr16_exec cr16_exec_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result       (result),
    .result_valid (result_valid),
    .illegal_op   (illegal_op),
    .flags        (flags)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic void model_alu(input alu_op_t op, input word_t a, input word_t b,
                                    output word_t res, output flags_t f);
    int         ua;
    int         ub;
    int         sa;
    int         sb;
    logic [3:0] amt;
    ua  = int'(a);
    ub  = int'(b);
    sa  = int'($signed(a));
    sb  = int'($signed(b));
    res = '0;
    f   = '0;
    case (op)
      `CR16_OP_ADD: begin
        res = 16'(ua + ub);
        f[`CR16_FLAG_C] = (ua + ub) > 65535;
        f[`CR16_FLAG_F] = ((sa + sb) > 32767) || ((sa + sb) < -32768);
      end
      `CR16_OP_SUB: begin
        res = 16'(ua - ub);
        // Borrow when b exceeds a
        f[`CR16_FLAG_C] = ua < ub;
        f[`CR16_FLAG_F] = ((sa - sb) > 32767) || ((sa - sb) < -32768);
      end
      // CMP writes no value, result reads zero
      `CR16_OP_CMP: begin
        f[`CR16_FLAG_Z] = ua == ub;
        f[`CR16_FLAG_N] = sa > sb;
        f[`CR16_FLAG_L] = ua > ub;
      end
      `CR16_OP_AND: res = a & b;
      `CR16_OP_OR:  res = a | b;
      `CR16_OP_XOR: res = a ^ b;
      `CR16_OP_LSH: begin
        // Right count is the 4-bit negation of the field
        amt = b[4] ? 4'(16 - int'(b[3:0])) : b[3:0];
        res = b[4] ? (a >> amt) : (a << amt);
      end
      `CR16_OP_LUI: res = {b[7:0], a[7:0]};
      `CR16_OP_MOV: res = b;
      default: res = '0;
    endcase
  endfunction

  function automatic instr_t make_imm(input alu_op_t op, input reg_addr_t rd,
                                      input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic instr_t make_reg(input alu_op_t op, input reg_addr_t rd,
                                      input reg_addr_t rs);
    return {`CR16_OP_REGFORM, rd, op, rs};
  endfunction

  // Decode one word, run the model, append the row
  function automatic void add_step(input instr_t iw);
    alu_op_t   op;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     res;
    flags_t    f;
    flags_t    mask;
    logic      legal;
    step_t     s;
    rd = iw[11:8];
    a  = model_regs[rd];
    if (iw[15:12] == `CR16_OP_REGFORM) begin
      op = iw[7:4];
      b  = model_regs[iw[3:0]];
    end else begin
      op = iw[15:12];
      if (op == `CR16_OP_ADD || op == `CR16_OP_SUB || op == `CR16_OP_CMP ||
          op == `CR16_OP_MOV)
        b = 16'(int'($signed(iw[7:0])));
      else
        b = {8'h00, iw[7:0]};
    end
    mask  = '0;
    legal = 1'b0;
    case (op)
      `CR16_OP_ADD, `CR16_OP_SUB: begin
        legal = 1'b1;
        mask[`CR16_FLAG_C] = 1'b1;
        mask[`CR16_FLAG_F] = 1'b1;
      end
      `CR16_OP_CMP: begin
        legal = 1'b1;
        mask[`CR16_FLAG_Z] = 1'b1;
        mask[`CR16_FLAG_N] = 1'b1;
        mask[`CR16_FLAG_L] = 1'b1;
      end
      `CR16_OP_AND, `CR16_OP_OR, `CR16_OP_XOR,
      `CR16_OP_LSH, `CR16_OP_LUI, `CR16_OP_MOV: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    model_alu(op, a, b, res, f);
    if (legal) begin
      for (int k = 0; k < `CR16_NUM_FLAGS; k++) begin
        if (mask[k]) model_flags[k] = f[k];
      end
      if (op != `CR16_OP_CMP) model_regs[rd] = res;
    end
    s.instr       = iw;
    s.exp_valid   = legal;
    s.exp_result  = res;
    s.exp_flags   = model_flags;
    s.exp_illegal = !legal;
    steps.push_back(s);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp === 1'b1 && act !== 1'b1) begin
      failures++;
      $display("At %0t the %s pulse did not come", $time, name);
    end else if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table();
    for (int r = 0; r < `CR16_NUM_REGS; r++) model_regs[r] = '0;
    model_flags = '0;
    // Register 3 is still zero
    add_step(make_reg(`CR16_OP_MOV, 4'd1, 4'd3));
    // Loads, negative byte sign-extends
    add_step(make_imm(`CR16_OP_MOV, 4'd2, 8'h85));
    add_step(make_imm(`CR16_OP_MOV, 4'd3, 8'h3c));
    add_step(make_imm(`CR16_OP_MOV, 4'd4, 8'($random(seed))));
    add_step(make_imm(`CR16_OP_MOV, 4'd5, 8'($random(seed))));
    // Register form, back to back
    add_step(make_reg(`CR16_OP_AND, 4'd2, 4'd3));
    add_step(make_reg(`CR16_OP_OR,  4'd4, 4'd3));
    add_step(make_reg(`CR16_OP_XOR, 4'd5, 4'd2));
    add_step(make_reg(`CR16_OP_LUI, 4'd3, 4'd4));
    add_step(make_reg(`CR16_OP_MOV, 4'd7, 4'd5));
    // Immediate logic ops, byte taken unsigned
    add_step(make_imm(`CR16_OP_AND, 4'd3, 8'hf0));
    add_step(make_imm(`CR16_OP_OR,  4'd3, 8'h80));
    add_step(make_imm(`CR16_OP_XOR, 4'd4, 8'($random(seed))));
    // Carry from adding minus one
    add_step(make_imm(`CR16_OP_MOV, 4'd8, 8'h7f));
    add_step(make_imm(`CR16_OP_ADD, 4'd8, 8'hff));
    // Signed overflow, 7f7e doubled
    add_step(make_imm(`CR16_OP_LUI, 4'd8, 8'h7f));
    add_step(make_reg(`CR16_OP_ADD, 4'd8, 4'd8));
    add_step(make_imm(`CR16_OP_OR,  4'd6, 8'h11));
    add_step(make_imm(`CR16_OP_ADD, 4'd6, 8'($random(seed))));
    // Borrow below zero, then 8000 minus one
    add_step(make_imm(`CR16_OP_SUB, 4'd9, 8'h01));
    add_step(make_imm(`CR16_OP_LUI, 4'd11, 8'h80));
    add_step(make_imm(`CR16_OP_SUB, 4'd11, 8'h01));
    // 7fff minus minus one, borrow and overflow together
    add_step(make_imm(`CR16_OP_SUB, 4'd11, 8'hff));
    add_step(make_imm(`CR16_OP_XOR, 4'd6, 8'h22));
    // Compares, equal, greater both ways, signed only
    add_step(make_imm(`CR16_OP_MOV, 4'd12, 8'h05));
    add_step(make_imm(`CR16_OP_CMP, 4'd12, 8'h05));
    add_step(make_imm(`CR16_OP_CMP, 4'd12, 8'h03));
    add_step(make_imm(`CR16_OP_CMP, 4'd12, 8'hff));
    add_step(make_reg(`CR16_OP_CMP, 4'd2, 4'd12));
    add_step(make_reg(`CR16_OP_MOV, 4'd13, 4'd12));
    // Shifts, zero and full counts both ways
    add_step(make_imm(`CR16_OP_MOV, 4'd14, 8'h69));
    add_step(make_imm(`CR16_OP_LSH, 4'd14, 8'h00));
    add_step(make_imm(`CR16_OP_LSH, 4'd14, 8'h04));
    add_step(make_imm(`CR16_OP_LSH, 4'd14, 8'h1c));
    add_step(make_imm(`CR16_OP_LSH, 4'd14, 8'h0f));
    add_step(make_imm(`CR16_OP_MOV, 4'd15, 8'hc3));
    add_step(make_imm(`CR16_OP_LSH, 4'd15, 8'h11));
    add_step(make_imm(`CR16_OP_MOV, 4'd15, 8'hc3));
    add_step(make_imm(`CR16_OP_LSH, 4'd15, 8'h10));
    add_step(make_imm(`CR16_OP_LSH, 4'd15, 8'h1f));
    add_step(make_reg(`CR16_OP_LSH, 4'd7, 4'd3));
    // Illegal words, then read the destination back
    add_step(16'h4e12);
    add_step(make_reg(`CR16_OP_MOV, 4'd1, 4'd14));
    add_step(make_reg(4'b0111, 4'd15, 4'd2));
    add_step(make_reg(4'b0000, 4'd12, 4'd3));
    add_step(make_reg(`CR16_OP_MOV, 4'd1, 4'd15));
    add_step(make_reg(`CR16_OP_MOV, 4'd1, 4'd12));
  endtask

  ////////////////////
  // Run control
  ////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    seed        = 34;
    mismatches  = 0;
    failures    = 0;
    cycles      = 0;
    cycle_limit = 50;
    build_table();
    cycle_limit = 4 * steps.size() + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet outputs straight out of reset
    @(negedge clk);
    check_bit("result_valid", 1'b0, result_valid);
    check_bit("illegal_op", 1'b0, illegal_op);
    check_flags("flags", '0, flags);
    check_word("result", '0, result);
    instr       = steps[0].instr;
    instr_valid = 1'b1;
    // Each row is checked one cycle after it is issued
    for (int i = 0; i < steps.size(); i++) begin
      @(negedge clk);
      check_bit("result_valid", steps[i].exp_valid, result_valid);
      check_bit("illegal_op", steps[i].exp_illegal, illegal_op);
      if (steps[i].exp_valid) check_word("result", steps[i].exp_result, result);
      check_flags("flags", steps[i].exp_flags, flags);
      if (i + 1 < steps.size()) begin
        instr = steps[i + 1].instr;
      end else begin
        instr_valid = 1'b0;
        instr       = '0;
      end
    end
    // Pulses drop once the stream stops
    @(negedge clk);
    check_bit("result_valid", 1'b0, result_valid);
    check_bit("illegal_op", 1'b0, illegal_op);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/cr16_pkg.sv
verilog/cr16_alu.sv
verilog/cr16_decode.sv
verilog/cr16_regfile.sv
verilog/cr16_writeback.sv
verilog/cr16_exec.sv
sim/cr16_exec_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute slice testbench

VERILATOR ?= verilator
TOP       ?= cr16_exec_tb
LOG       ?= sim.log
FLAGS     ?= --binary --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f

.PHONY: sim clean

# Build, run into the log, fail on the fail message or a bad exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Checks failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
